//--- filelist.f
source/usiPkg.sv
source/usiBus.sv
source/usiGpio.sv
source/usiPwm.sv
source/usiSubsystem.sv
tests/usiSubsystemTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the USI subsystem testbench with Verilator
# The result comes from the testbench's closing message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module usiSubsystemTb \
	-f filelist.f \
	-o usiSim \
	&& ./obj_dir/usiSim | tee /dev/stderr | grep -x "TEST PASS" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- source/usiBus.sv
// USI bus core
// Command register, bus address decode, read data mux and ready register

`timescale 1ns/1ps

module usiBus
	import usiPkg::*;
(
	input  logic                     iUsiClk,
	input  logic                     rstN,
	// Master side
	input  usiCmdT                   mCmd,
	input  logic                     mCmdValid,	// Sampled every cycle, no stall
	output logic [31:0]              mRd,
	output logic [lpBusSlaveNum-1:0] mRdy,	// Bit 0 GPIO, bit 1 PWM
	// Slave side
	output usiCmdT                   slvCmd,	// Shared by both slaves
	output logic                     gpioSel,
	output logic                     pwmSel,
	input  usiRspT                   gpioRsp,
	input  usiRspT                   pwmRsp
);

	// ----------------------------------------
	// Address decode
	// ----------------------------------------
	logic gpioHit;
	logic pwmHit;

	always_comb
	begin
		gpioHit = mCmdValid && (mCmd.busAdrs == lpBusAdrsGpio);
		pwmHit  = mCmdValid && (mCmd.busAdrs == lpBusAdrsPwm);
	end

	// ----------------------------------------
	// Command stage, edge N
	// ----------------------------------------
	logic rCmdVld;	// A command sits in slvCmd

	always_ff @(posedge iUsiClk or negedge rstN)
	begin
		if (!rstN)
		begin
			gpioSel <= 1'b0;
			pwmSel  <= 1'b0;
			rCmdVld <= 1'b0;
		end
		else
		begin
			gpioSel <= gpioHit;	// One-cycle strobes
			pwmSel  <= pwmHit;	// Unmapped address raises neither
			rCmdVld <= mCmdValid;
		end
	end

	// Payload follows the strobe, held otherwise
	always_ff @(posedge iUsiClk)
	begin
		if (mCmdValid)
			slvCmd <= mCmd;
	end

	// ----------------------------------------
	// Read tracking, edge N+1
	// ----------------------------------------
	// Address copy lines up with the slave rd register
	logic       rRdPend;
	logic [7:0] rRdAdrs;

	always_ff @(posedge iUsiClk or negedge rstN)
	begin
		if (!rstN)
			rRdPend <= 1'b0;
		else
			rRdPend <= rCmdVld && (slvCmd.cmd == cmdRead);
	end

	always_ff @(posedge iUsiClk)
	begin
		if (rCmdVld && (slvCmd.cmd == cmdRead))
			rRdAdrs <= slvCmd.busAdrs;
	end

	// ----------------------------------------
	// Read mux and ready, edge N+2
	// ----------------------------------------
	always_ff @(posedge iUsiClk or negedge rstN)
	begin
		if (!rstN)
		begin
			mRd  <= '0;
			mRdy <= '0;
		end
		else
		begin
			mRdy <= {pwmRsp.rdy, gpioRsp.rdy};	// Advisory only
			if (rRdPend)	// Holds until the next read returns
			begin
				case (rRdAdrs)
					lpBusAdrsGpio: mRd <= gpioRsp.rd;
					lpBusAdrsPwm:  mRd <= pwmRsp.rd;
					default:       mRd <= lpRdDefault;	// Unmapped slave
				endcase
			end
		end
	end

endmodule

//--- source/usiGpio.sv
// GPIO slave on the USI bus
// Output and direction registers, synchronized input register

`timescale 1ns/1ps

module usiGpio
	import usiPkg::*;
(
	input  logic                   iUsiClk,
	input  logic                   rstN,
	input  usiCmdT                 slvCmd,
	input  logic                   sel,	// One-cycle strobe from the bus
	output usiRspT                 rsp,
	input  logic [lpGpioWidth-1:0] gpioIn,	// Asynchronous pins
	output logic [lpGpioWidth-1:0] gpioOut,
	output logic [lpGpioWidth-1:0] gpioOe
);

	logic                   wrEn;
	logic                   rdEn;
	logic [lpGpioWidth-1:0] rOut;	// Output levels
	logic [lpGpioWidth-1:0] rDir;	// Output enables
	logic [lpGpioWidth-1:0] rInMeta;	// First synchronizer stage
	logic [lpGpioWidth-1:0] rInSync;	// Input register as read back
	logic [31:0]            rRd;
	logic                   rRdy;

	// Write-and-read and none fall through here
	assign wrEn = sel && (slvCmd.cmd == cmdWrite);
	assign rdEn = sel && (slvCmd.cmd == cmdRead);

	// ----------------------------------------
	// CSR writes, edge N+1
	// ----------------------------------------
	always_ff @(posedge iUsiClk or negedge rstN)
	begin
		if (!rstN)
		begin
			rOut <= '0;
			rDir <= '0;
		end
		else if (wrEn)
		begin
			case (slvCmd.csrAdrs)
				lpCsrGpioOut: rOut <= slvCmd.wd[lpGpioWidth-1:0];
				lpCsrGpioDir: rDir <= slvCmd.wd[lpGpioWidth-1:0];
				default:;	// Input register is read only
			endcase
		end
	end

	// Two-flop synchronizer on the pins
	always_ff @(posedge iUsiClk or negedge rstN)
	begin
		if (!rstN)
		begin
			rInMeta <= '0;
			rInSync <= '0;
		end
		else
		begin
			rInMeta <= gpioIn;
			rInSync <= rInMeta;
		end
	end

	// ----------------------------------------
	// Read data and ready
	// ----------------------------------------
	always_ff @(posedge iUsiClk)
	begin
		if (rdEn)
		begin
			case (slvCmd.csrAdrs)
				lpCsrGpioOut: rRd <= 32'(rOut);
				lpCsrGpioDir: rRd <= 32'(rDir);
				lpCsrGpioIn:  rRd <= 32'(rInSync);
				default:      rRd <= '0;	// Unknown offset
			endcase
		end
	end

	// Low for one cycle after each write, rises after reset
	always_ff @(posedge iUsiClk or negedge rstN)
	begin
		if (!rstN)
			rRdy <= 1'b0;
		else
			rRdy <= !wrEn;
	end

	assign rsp     = '{rd: rRd, rdy: rRdy};
	assign gpioOut = rOut;
	assign gpioOe  = rDir;

endmodule

//--- source/usiPkg.sv
// Shared definitions for the USI register bus
// Command codes, bus address map, CSR offsets and bus structs

package usiPkg;

	// ----------------------------------------
	// Command codes, word bits 31:30
	// ----------------------------------------
	typedef enum logic [1:0]
	{
		cmdNone      = 2'd0,	// Idle slot
		cmdWrite     = 2'd1,
		cmdRead      = 2'd2,
		cmdWriteRead = 2'd3	// Not implemented, slaves ignore it
	} usiCmdE;

	// ----------------------------------------
	// Bus address map, word bits 23:16
	// ----------------------------------------
	localparam logic [7:0] lpBusAdrsGpio = 8'h01;
	localparam logic [7:0] lpBusAdrsPwm  = 8'h02;

	localparam int lpBusSlaveNum = 2;	// GPIO and PWM

	// Returned for an unmapped bus address so decode bugs stand out
	localparam logic [31:0] lpRdDefault = 32'h1234_5678;

	// ----------------------------------------
	// CSR offsets, word bits 15:0
	// ----------------------------------------
	// GPIO block
	localparam logic [15:0] lpCsrGpioOut = 16'h0000;	// Output levels
	localparam logic [15:0] lpCsrGpioDir = 16'h0004;	// 1 drives the pin
	localparam logic [15:0] lpCsrGpioIn  = 16'h0008;	// Read only

	// PWM block
	localparam logic [15:0] lpCsrPwmPeriod = 16'h0000;	// Counter wraps after this
	localparam logic [15:0] lpCsrPwmDuty   = 16'h0004;	// High while count below
	localparam logic [15:0] lpCsrPwmEnable = 16'h0008;	// Bit 0 only

	// Peripheral sizes
	localparam int lpGpioWidth = 16;	// Pin count
	localparam int lpPwmWidth  = 16;	// Counter width

	// ----------------------------------------
	// Bus structs
	// ----------------------------------------
	// One command as it crosses the bus, 58 bits
	typedef struct packed
	{
		usiCmdE      cmd;
		logic [7:0]  busAdrs;	// Decoded by the bus only
		logic [15:0] csrAdrs;	// Decoded by the slave
		logic [31:0] wd;	// Write data
	} usiCmdT;

	// Slave response, 33 bits
	typedef struct packed
	{
		logic [31:0] rd;	// Registered read data
		logic        rdy;	// Low one cycle after a write
	} usiRspT;

endpackage

//--- source/usiPwm.sv
// PWM slave on the USI bus
// Period, duty and enable registers with a free-running counter

`timescale 1ns/1ps

module usiPwm
	import usiPkg::*;
(
	input  logic   iUsiClk,
	input  logic   rstN,
	input  usiCmdT slvCmd,
	input  logic   sel,	// One-cycle strobe from the bus
	output usiRspT rsp,
	output logic   pwmOut
);

	logic                  wrEn;
	logic                  rdEn;
	logic [lpPwmWidth-1:0] rPeriod;	// Last count before wrap
	logic [lpPwmWidth-1:0] rDuty;	// High count per period
	logic                  rEnable;
	logic [lpPwmWidth-1:0] rCnt;
	logic [31:0]           rRd;
	logic                  rRdy;

	assign wrEn = sel && (slvCmd.cmd == cmdWrite);
	assign rdEn = sel && (slvCmd.cmd == cmdRead);

	// ----------------------------------------
	// CSR writes, edge N+1
	// ----------------------------------------
	always_ff @(posedge iUsiClk or negedge rstN)
	begin
		if (!rstN)
		begin
			rPeriod <= '0;
			rDuty   <= '0;
			rEnable <= 1'b0;
		end
		else if (wrEn)
		begin
			case (slvCmd.csrAdrs)
				lpCsrPwmPeriod: rPeriod <= slvCmd.wd[lpPwmWidth-1:0];
				lpCsrPwmDuty:   rDuty   <= slvCmd.wd[lpPwmWidth-1:0];
				lpCsrPwmEnable: rEnable <= slvCmd.wd[0];
				default:;	// Unknown offset dropped
			endcase
		end
	end

	// ----------------------------------------
	// Counter and output
	// ----------------------------------------
	// Runs 0..period, so one period lasts period+1 cycles
	always_ff @(posedge iUsiClk or negedge rstN)
	begin
		if (!rstN)
			rCnt <= '0;
		else if (!rEnable)
			rCnt <= '0;	// Parked while disabled
		else if (rCnt >= rPeriod)
			rCnt <= '0;	// Wrap, also catches a period shrink
		else
			rCnt <= rCnt + 1'b1;
	end

	// Duty above period gives a steady high
	assign pwmOut = rEnable && (rCnt < rDuty);

	// ----------------------------------------
	// Read data and ready
	// ----------------------------------------
	always_ff @(posedge iUsiClk)
	begin
		if (rdEn)
		begin
			case (slvCmd.csrAdrs)
				lpCsrPwmPeriod: rRd <= 32'(rPeriod);
				lpCsrPwmDuty:   rRd <= 32'(rDuty);
				lpCsrPwmEnable: rRd <= 32'(rEnable);
				default:        rRd <= '0;
			endcase
		end
	end

	// Same ready rule as the GPIO block
	always_ff @(posedge iUsiClk or negedge rstN)
	begin
		if (!rstN)
			rRdy <= 1'b0;
		else
			rRdy <= !wrEn;
	end

	assign rsp = '{rd: rRd, rdy: rRdy};

endmodule

//--- source/usiSubsystem.sv
// USI subsystem top
// Bus core with the GPIO and PWM slaves

`timescale 1ns/1ps

module usiSubsystem
	import usiPkg::*;
(
	input  logic                     iUsiClk,
	input  logic                     rstN,
	// Master port
	input  usiCmdT                   mCmd,
	input  logic                     mCmdValid,
	output logic [31:0]              mRd,
	output logic [lpBusSlaveNum-1:0] mRdy,
	// Pins
	input  logic [lpGpioWidth-1:0]   gpioIn,
	output logic [lpGpioWidth-1:0]   gpioOut,
	output logic [lpGpioWidth-1:0]   gpioOe,
	output logic                     pwmOut
);

	// Bus to slave wiring
	usiCmdT slvCmd;	// Registered command, fanned out
	logic   gpioSel;
	logic   pwmSel;
	usiRspT gpioRsp;
	usiRspT pwmRsp;

	usiBus i_usiBus (
		.iUsiClk   (iUsiClk),
		.rstN      (rstN),
		.mCmd      (mCmd),
		.mCmdValid (mCmdValid),
		.mRd       (mRd),
		.mRdy      (mRdy),
		.slvCmd    (slvCmd),
		.gpioSel   (gpioSel),
		.pwmSel    (pwmSel),
		.gpioRsp   (gpioRsp),
		.pwmRsp    (pwmRsp)
	);

	// Bus address 0x01
	usiGpio i_usiGpio (
		.iUsiClk (iUsiClk),
		.rstN    (rstN),
		.slvCmd  (slvCmd),
		.sel     (gpioSel),
		.rsp     (gpioRsp),
		.gpioIn  (gpioIn),
		.gpioOut (gpioOut),
		.gpioOe  (gpioOe)
	);

	// Bus address 0x02
	usiPwm i_usiPwm (
		.iUsiClk (iUsiClk),
		.rstN    (rstN),
		.slvCmd  (slvCmd),
		.sel     (pwmSel),
		.rsp     (pwmRsp),
		.pwmOut  (pwmOut)
	);

endmodule

//--- tests/usiSubsystemTb.sv
// Testbench for the USI subsystem
// Clock, reset, bus tasks, checks, watchdog and report

`timescale 1ns/1ps

module usiSubsystemTb
	import usiPkg::*;
();

	localparam int lpClkPeriod = 10;
	// Cycle budget per test, watchdog allows twice the sum
	localparam int lpBudgetReset  = 10;
	localparam int lpBudgetGpio   = 120;	// 8 rounds of 2 writes, 2 reads
	localparam int lpBudgetGpioIn = 30;
	localparam int lpBudgetPwm    = 210;	// 3 configs plus disable
	localparam int lpBudgetDecode = 60;
	localparam int lpBudgetTotal  = lpBudgetReset + lpBudgetGpio + lpBudgetGpioIn
		+ lpBudgetPwm + lpBudgetDecode;

	logic                     iUsiClk;
	logic                     rstN;
	usiCmdT                   mCmd;
	logic                     mCmdValid;
	logic [31:0]              mRd;
	logic [lpBusSlaveNum-1:0] mRdy;
	logic [lpGpioWidth-1:0]   gpioIn;
	logic [lpGpioWidth-1:0]   gpioOut;
	logic [lpGpioWidth-1:0]   gpioOe;
	logic                     pwmOut;

	int   failCnt;
	int   checkCnt;
	int   testFailBase;	// failCnt when the current test started
	logic rdyArmed;	// Enables the ready property after reset

	// Register contents the DUT should hold
	logic [15:0] expGpioOut;
	logic [15:0] expGpioDir;
	logic [15:0] expPeriod;
	logic [15:0] expDuty;
	logic        expEnable;
	logic [15:0] outAtN2;	// Pins seen at edge N+2 of the last write
	logic [15:0] oeAtN2;

	usiSubsystem i_usiSubsystem (
		.iUsiClk   (iUsiClk),
		.rstN      (rstN),
		.mCmd      (mCmd),
		.mCmdValid (mCmdValid),
		.mRd       (mRd),
		.mRdy      (mRdy),
		.gpioIn    (gpioIn),
		.gpioOut   (gpioOut),
		.gpioOe    (gpioOe),
		.pwmOut    (pwmOut)
	);

	initial
	begin
		iUsiClk = 1'b0;
		forever #(lpClkPeriod / 2) iUsiClk = ~iUsiClk;
	end

	// A write drops only its own slave bit, so both low never happens
	rdyOneHigh: assert property (@(posedge iUsiClk) disable iff (!rdyArmed) mRdy != 2'b00)
	else
	begin
		failCnt++;
		$display("FAILED mRdy both low, got 0x%h", mRdy);
	end

	// ----------------------------------------
	// Check and report helpers
	// ----------------------------------------
	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCnt++;
		assert (got === exp)
		else
		begin
			failCnt++;
			$display("FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic checkTrue(input logic cond, input string msg);
		checkCnt++;
		assert (cond)
		else
		begin
			failCnt++;
			$display("%s", msg);
		end
	endtask

	task automatic endTest(input string name);
		$display("Test %-8s done, %0d failures", name, failCnt - testFailBase);
		testFailBase = failCnt;
	endtask

	// mRdy bit of a bus address, -1 when unmapped
	function automatic int slaveIdx(input logic [7:0] busAdrs);
		if (busAdrs == lpBusAdrsGpio)
			return 0;
		else if (busAdrs == lpBusAdrsPwm)
			return 1;
		return -1;
	endfunction

	// ----------------------------------------
	// Bus tasks, entered 1 ns after an edge
	// ----------------------------------------
	task automatic issueCmd(input usiCmdE cmd, input logic [7:0] busAdrs,
		input logic [15:0] csrAdrs, input logic [31:0] wd);
		mCmd      = '{cmd: cmd, busAdrs: busAdrs, csrAdrs: csrAdrs, wd: wd};
		mCmdValid = 1'b1;
		@(posedge iUsiClk);	// Edge N samples it
		#1;
		mCmdValid = 1'b0;
		mCmd      = '0;
	endtask

	// Write plus ready pulse check on the addressed slave
	task automatic busWrite(input usiCmdE cmd, input logic [7:0] busAdrs,
		input logic [15:0] csrAdrs, input logic [31:0] wd);
		int         idx;
		logic [1:0] expRdy;
		idx = (cmd == cmdWrite) ? slaveIdx(busAdrs) : -1;	// Others raise no pulse
		expRdy = (idx == 0) ? 2'b10 : ((idx == 1) ? 2'b01 : 2'b11);
		issueCmd(cmd, busAdrs, csrAdrs, wd);
		@(posedge iUsiClk);	// N+1
		#1;
		checkEq("mRdy", 32'(mRdy), 32'(2'b11));
		@(posedge iUsiClk);	// N+2
		#1;
		outAtN2 = gpioOut;
		oeAtN2  = gpioOe;
		checkEq("mRdy", 32'(mRdy), 32'(expRdy));
		@(posedge iUsiClk);	// N+3, recovered
		#1;
		checkEq("mRdy", 32'(mRdy), 32'(2'b11));
	endtask

	task automatic busRead(input logic [7:0] busAdrs, input logic [15:0] csrAdrs,
		output logic [31:0] data);
		issueCmd(cmdRead, busAdrs, csrAdrs, 32'h0);
		@(posedge iUsiClk);
		@(posedge iUsiClk);	// mRd loaded at N+2
		#1;
		data = mRd;
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial
	begin
		logic [31:0] wd;
		logic [31:0] rdVal;
		logic [7:0]  pipeBus [4];
		logic [15:0] pipeCsr [4];
		logic [31:0] pipeExp [4];
		int          waitCnt;
		int          period;
		int          duty;
		int          highCnt;
		int          expHigh;

		void'($urandom(9128));
		rstN = 1'b0;
		mCmd = '0;
		mCmdValid = 1'b0;
		gpioIn = '0;
		rdyArmed = 1'b0;
		failCnt = 0;
		checkCnt = 0;
		testFailBase = 0;
		expGpioOut = '0;
		expGpioDir = '0;
		expPeriod = '0;
		expDuty = '0;
		expEnable = 1'b0;

		// Reset state
		repeat (5) @(posedge iUsiClk);
		#1;
		checkEq("mRd", mRd, 32'h0);
		checkEq("mRdy", 32'(mRdy), 32'h0);
		checkEq("gpioOut", 32'(gpioOut), 32'h0);
		checkEq("gpioOe", 32'(gpioOe), 32'h0);
		checkEq("pwmOut", 32'(pwmOut), 32'h0);
		rstN = 1'b1;
		waitCnt = 0;
		while (mRdy != 2'b11 && waitCnt < 3)
		begin
			@(posedge iUsiClk);
			#1;
			waitCnt++;
		end
		checkTrue(mRdy == 2'b11, "mRdy did not rise within three cycles of reset release");
		rdyArmed = 1'b1;
		endTest("reset");

		// GPIO read-back with random words
		repeat (8)
		begin
			wd = $urandom();
			busWrite(cmdWrite, lpBusAdrsGpio, lpCsrGpioOut, wd);
			expGpioOut = wd[15:0];
			checkEq("gpioOut", 32'(outAtN2), 32'(expGpioOut));
			wd = $urandom();
			busWrite(cmdWrite, lpBusAdrsGpio, lpCsrGpioDir, wd);
			expGpioDir = wd[15:0];
			checkEq("gpioOe", 32'(oeAtN2), 32'(expGpioDir));
			busRead(lpBusAdrsGpio, lpCsrGpioOut, rdVal);
			checkEq("mRd", rdVal, 32'(expGpioOut));
			busRead(lpBusAdrsGpio, lpCsrGpioDir, rdVal);
			checkEq("mRd", rdVal, 32'(expGpioDir));
		end
		endTest("gpio");

		// Input pins through the synchronizer
		repeat (4)
		begin
			gpioIn = 16'($urandom());
			repeat (3) @(posedge iUsiClk);
			#1;
			busRead(lpBusAdrsGpio, lpCsrGpioIn, rdVal);
			checkEq("mRd", rdVal, 32'(gpioIn));
		end
		endTest("gpioIn");

		// PWM: fixed, duty above period, then random
		for (int cfg = 0; cfg < 3; cfg++)
		begin
			period = (cfg == 0) ? 9 : ((cfg == 1) ? 5 : int'($urandom_range(17, 2)));
			duty   = (cfg == 0) ? 4 : ((cfg == 1) ? 20 : int'($urandom_range(period + 3, 0)));
			expPeriod = 16'(period);
			expDuty   = 16'(duty);
			expEnable = 1'b1;
			busWrite(cmdWrite, lpBusAdrsPwm, lpCsrPwmPeriod, 32'(expPeriod));
			busWrite(cmdWrite, lpBusAdrsPwm, lpCsrPwmDuty, 32'(expDuty));
			busWrite(cmdWrite, lpBusAdrsPwm, lpCsrPwmEnable, 32'h1);
			busRead(lpBusAdrsPwm, lpCsrPwmPeriod, rdVal);
			checkEq("mRd", rdVal, 32'(expPeriod));
			busRead(lpBusAdrsPwm, lpCsrPwmDuty, rdVal);
			checkEq("mRd", rdVal, 32'(expDuty));
			busRead(lpBusAdrsPwm, lpCsrPwmEnable, rdVal);
			checkEq("mRd", rdVal, 32'(expEnable));
			repeat (period + 2) @(posedge iUsiClk);	// Let a period change settle
			#1;
			expHigh = (duty > period + 1) ? period + 1 : duty;
			highCnt = 0;
			repeat (period + 1)	// Any window of one period
			begin
				if (pwmOut)
					highCnt++;
				@(posedge iUsiClk);
				#1;
			end
			checkEq("pwmOut high count", 32'(highCnt), 32'(expHigh));
		end
		expEnable = 1'b0;
		busWrite(cmdWrite, lpBusAdrsPwm, lpCsrPwmEnable, 32'h0);
		repeat (20)
		begin
			checkEq("pwmOut", 32'(pwmOut), 32'h0);
			@(posedge iUsiClk);
			#1;
		end
		busRead(lpBusAdrsPwm, lpCsrPwmEnable, rdVal);
		checkEq("mRd", rdVal, 32'(expEnable));
		endTest("pwm");

		// ----------------------------------------
		// Address decode
		// ----------------------------------------
		busRead(8'h05, 16'h0000, rdVal);
		checkEq("mRd", rdVal, 32'h1234_5678);	// Marker word for an unmapped slave
		// None of these may touch a register
		busWrite(cmdWrite, 8'h07, lpCsrGpioOut, $urandom());
		busWrite(cmdWrite, 8'h00, lpCsrPwmPeriod, $urandom());
		busWrite(cmdWrite, lpBusAdrsGpio, lpCsrGpioIn, $urandom());
		busWrite(cmdNone, lpBusAdrsGpio, lpCsrGpioOut, $urandom());
		busWrite(cmdWriteRead, lpBusAdrsGpio, lpCsrGpioDir, $urandom());
		busWrite(cmdWriteRead, lpBusAdrsPwm, lpCsrPwmDuty, $urandom());
		busRead(lpBusAdrsGpio, lpCsrGpioOut, rdVal);
		checkEq("mRd", rdVal, 32'(expGpioOut));
		busRead(lpBusAdrsGpio, lpCsrGpioDir, rdVal);
		checkEq("mRd", rdVal, 32'(expGpioDir));
		busRead(lpBusAdrsGpio, lpCsrGpioIn, rdVal);
		checkEq("mRd", rdVal, 32'(gpioIn));
		busRead(lpBusAdrsPwm, lpCsrPwmPeriod, rdVal);
		checkEq("mRd", rdVal, 32'(expPeriod));
		busRead(lpBusAdrsPwm, lpCsrPwmDuty, rdVal);
		checkEq("mRd", rdVal, 32'(expDuty));

		// Back-to-back reads, alternating slaves
		pipeBus = '{lpBusAdrsGpio, lpBusAdrsPwm, lpBusAdrsGpio, lpBusAdrsPwm};
		pipeCsr = '{lpCsrGpioOut, lpCsrPwmPeriod, lpCsrGpioDir, lpCsrPwmDuty};
		pipeExp = '{32'(expGpioOut), 32'(expPeriod), 32'(expGpioDir), 32'(expDuty)};
		for (int i = 0; i < 6; i++)
		begin
			if (i < 4)
			begin
				mCmd = '{cmd: cmdRead, busAdrs: pipeBus[i], csrAdrs: pipeCsr[i], wd: 32'h0};
				mCmdValid = 1'b1;
			end
			else
			begin
				mCmd = '0;
				mCmdValid = 1'b0;
			end
			@(posedge iUsiClk);
			#1;
			if (i >= 2)	// Read i-2 lands two edges later
				checkEq("mRd", mRd, pipeExp[i - 2]);
		end
		endTest("decode");

		$display("Checks %0d, failures %0d", checkCnt, failCnt);
		if (failCnt == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(lpBudgetTotal * 2 * lpClkPeriod);
		$display("Watchdog expired after %0d cycles, the run did not finish", lpBudgetTotal * 2);
		$display("TEST FAIL");
		$finish;
	end

endmodule
